// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --timescale 1ns/10ps -j 0
TOP      := tb_iommu_ptw
FILELIST := sources.f
OBJ_DIR  := obj_dir
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
verilog/ptw_pkg.sv
verilog/ptw_pte_check.sv
verilog/ptw_pptr_gen.sv
verilog/ptw_iotlb_update.sv
verilog/ptw_walk_ctrl.sv
verilog/iommu_ptw.sv
testbench/tb_iommu_ptw.sv

// ==== testbench/ptw_input.txt ====
// iova pscid root_ppn store pte0 pte1 pte2 ar_dly r_dly err_read kind(1=update) cause size content
// err_read counts reads from 1 (0 = none), size is {1g,2m}, content is the expected up_content_o
1234567000 00001 80000 0 20000401 20000801 048D14CF 0 0 0 1 000 0 048D14CF
1234567000 00002 80000 1 20000401 20000801 048D14CF 3 2 0 1 000 0 048D14CF
7FC0201000 00a5c 80010 0 300000CF 0 0 1 1 0 1 000 2 300000CF
0040200000 0ffff 80020 1 20000401 200800CF 0 0 1 0 1 000 1 200800CF
3ABCDE5000 12345 80000 0 20000421 20000801 048D14CF 1 0 0 1 000 0 048D14EF
7FC0201000 00003 80000 0 300004CF 0 0 0 0 0 0 00D 0 0
0040200000 00004 80000 1 20000401 200804CF 0 0 0 0 0 00F 0 0
1234567000 00005 80000 0 20000400 0 0 0 0 0 0 00D 0 0
1234567000 00006 80000 1 20000401 20000805 0 2 0 0 0 00F 0 0
1234567000 00007 80000 0 8000000020000401 0 0 0 2 0 0 00D 0 0
3ABCDE5000 00008 80000 1 20000441 0 0 0 0 0 0 00F 0 0
3ABCDE5000 00009 80000 0 20000401 20000801 20000C01 1 1 0 0 00D 0 0
1234567000 0000a 80000 1 20000401 20000801 048D1447 0 0 0 0 00F 0 0
1234567000 0000a 80000 0 20000401 20000801 048D1447 0 0 0 1 000 0 048D1447
5555555000 0000b 80000 1 20000401 200800CF 0 0 0 2 0 112 0 0
5555555000 0000c 80000 0 20000401 0 0 4 5 1 0 112 0 0
2AAAAAA000 fffff 80030 0 20000401 20000821 048D14CF 6 4 0 1 000 0 048D14EF
7FC0201000 0000d 80000 0 3000008F 0 0 0 0 0 0 00D 0 0
1234567000 0000e 80000 0 20000401 20000801 048D14C9 0 1 0 0 00D 0 0
0000001000 0000f 80000 1 300000EF 0 0 2 0 0 1 000 2 300000EF

// ==== testbench/tb_iommu_ptw.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_iommu_ptw;

    // Words per line of the input file
    localparam int NF          = 14;
    localparam int MAX_VECS    = 32;
    // Watchdog budget per walk
    localparam int WALK_CYCLES = 200;
    // Longest wait for a read request
    localparam int AR_WAIT_MAX = 20;

    logic                         clk_i;
    logic                         rst_ni;
    logic                         init_ptw_i;
    logic [ptw_pkg::VLEN-1:0]     req_iova_i;
    logic [ptw_pkg::PSCIDW-1:0]   pscid_i;
    logic [ptw_pkg::PPNW-1:0]     iosatp_ppn_i;
    logic                         is_store_i;
    logic                         mem_ar_valid_o;
    logic [ptw_pkg::PLEN-1:0]     mem_ar_addr_o;
    logic                         mem_ar_ready_i;
    logic                         mem_r_valid_i;
    logic [ptw_pkg::PTE_W-1:0]    mem_r_data_i;
    logic                         mem_r_err_i;
    logic                         mem_r_ready_o;
    logic                         update_o;
    logic [ptw_pkg::VPNW-1:0]     up_vpn_o;
    logic [ptw_pkg::PSCIDW-1:0]   up_pscid_o;
    logic                         up_1g_o;
    logic                         up_2m_o;
    ptw_pkg::pte_t                up_content_o;
    logic                         ptw_error_o;
    ptw_pkg::cause_e              cause_code_o;
    logic                         ptw_active_o;

    // Stimulus words with NF per walk
    logic [63:0] vec_mem [0:NF*MAX_VECS-1];
    int          num_vecs;
    logic        vecs_loaded = 1'b0;
    int          num_checks;
    int          value_errors;
    int          other_errors;
    integer      seed;

    iommu_ptw u_iommu_ptw (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .init_ptw_i     (init_ptw_i),
        .req_iova_i     (req_iova_i),
        .pscid_i        (pscid_i),
        .iosatp_ppn_i   (iosatp_ppn_i),
        .is_store_i     (is_store_i),
        .mem_ar_valid_o (mem_ar_valid_o),
        .mem_ar_addr_o  (mem_ar_addr_o),
        .mem_ar_ready_i (mem_ar_ready_i),
        .mem_r_valid_i  (mem_r_valid_i),
        .mem_r_data_i   (mem_r_data_i),
        .mem_r_err_i    (mem_r_err_i),
        .mem_r_ready_o  (mem_r_ready_o),
        .update_o       (update_o),
        .up_vpn_o       (up_vpn_o),
        .up_pscid_o     (up_pscid_o),
        .up_1g_o        (up_1g_o),
        .up_2m_o        (up_2m_o),
        .up_content_o   (up_content_o),
        .ptw_error_o    (ptw_error_o),
        .cause_code_o   (cause_code_o),
        .ptw_active_o   (ptw_active_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // Inputs change 1 ns after the rising edge
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_pte(input string name, input ptw_pkg::pte_t exp,
                             input ptw_pkg::pte_t got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_cause(input string name, input ptw_pkg::cause_e exp,
                               input ptw_pkg::cause_e got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%0d got=%0d", $time, name, exp, got);
        end
    endtask

    task automatic check_addr(input string name, input logic [ptw_pkg::PLEN-1:0] exp,
                              input logic [ptw_pkg::PLEN-1:0] got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%b got=%b", $time, name, exp, got);
        end
    endtask

    // VPN tag of the update
    task automatic check_vpn(input string name, input logic [ptw_pkg::VPNW-1:0] exp,
                             input logic [ptw_pkg::VPNW-1:0] got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // PSCID tag of the update
    task automatic check_pscid(input string name, input logic [ptw_pkg::PSCIDW-1:0] exp,
                               input logic [ptw_pkg::PSCIDW-1:0] got);
        num_checks++;
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // Extra 0..3 cycles on top of a file delay
    task automatic draw_extra(output int extra);
        logic [31:0] rnd;
        rnd   = $random(seed);
        extra = {30'd0, rnd[1:0]};
    endtask

    task automatic run_walk(input int v);
        int                       b;
        int                       n;
        int                       k;
        int                       extra;
        int                       ar_dly;
        int                       r_dly;
        int                       err_idx;
        logic                     done;
        logic                     upd_seen;
        logic                     err_seen;
        logic                     exp_upd;
        logic [1:0]               exp_size;
        ptw_pkg::cause_e          exp_cause;
        ptw_pkg::pte_t            exp_content;
        ptw_pkg::pte_t            cur_pte;
        logic [ptw_pkg::VLEN-1:0] iova;
        logic [ptw_pkg::PLEN-1:0] exp_addr;

        b           = v * NF;
        iova        = vec_mem[b][ptw_pkg::VLEN-1:0];
        err_idx     = {30'd0, vec_mem[b+9][1:0]};
        exp_upd     = vec_mem[b+10][0];
        exp_cause   = ptw_pkg::cause_e'(vec_mem[b+11][ptw_pkg::CAUSE_LEN-1:0]);
        exp_size    = vec_mem[b+12][1:0];
        exp_content = ptw_pkg::pte_t'(vec_mem[b+13]);
        n           = 0;
        done        = 1'b0;
        upd_seen    = 1'b0;
        err_seen    = 1'b0;

        // One-cycle start with the request fields
        tick();
        init_ptw_i   = 1'b1;
        req_iova_i   = iova;
        pscid_i      = vec_mem[b+1][ptw_pkg::PSCIDW-1:0];
        iosatp_ppn_i = vec_mem[b+2][ptw_pkg::PPNW-1:0];
        is_store_i   = vec_mem[b+3][0];
        tick();
        init_ptw_i = 1'b0;
        // Root entry indexed by VPN[2]
        exp_addr = {iosatp_ppn_i, iova[38:30], 3'b000};

        while (!done) begin
            @(negedge clk_i);
            k = 0;
            while (!mem_ar_valid_o && k < AR_WAIT_MAX) begin
                tick();
                @(negedge clk_i);
                k++;
            end
            if (!mem_ar_valid_o) begin
                other_errors++;
                $display("Walk %0d: no read request issued for read %0d", v, n + 1);
                return;
            end
            check_addr("mem_ar_addr_o", exp_addr, mem_ar_addr_o);
            check_bit("ptw_active_o", 1'b1, ptw_active_o);
            // Request must hold while ready stays low
            draw_extra(extra);
            ar_dly = {24'd0, vec_mem[b+7][7:0]} + extra;
            repeat (ar_dly) begin
                tick();
                @(negedge clk_i);
                check_bit("mem_ar_valid_o", 1'b1, mem_ar_valid_o);
                check_addr("mem_ar_addr_o", exp_addr, mem_ar_addr_o);
            end
            tick();
            mem_ar_ready_i = 1'b1;
            tick();
            mem_ar_ready_i = 1'b0;
            // Response latency
            draw_extra(extra);
            r_dly = {24'd0, vec_mem[b+8][7:0]} + extra;
            repeat (r_dly) begin
                @(negedge clk_i);
                check_bit("mem_ar_valid_o", 1'b0, mem_ar_valid_o);
                check_bit("mem_r_ready_o", 1'b0, mem_r_ready_o);
                tick();
            end
            // n-th read answered with the n-th PTE word
            cur_pte       = ptw_pkg::pte_t'(vec_mem[b+4+n]);
            mem_r_valid_i = 1'b1;
            mem_r_data_i  = cur_pte;
            mem_r_err_i   = (err_idx == n + 1);
            @(negedge clk_i);
            check_bit("mem_r_ready_o", 1'b1, mem_r_ready_o);
            upd_seen = update_o;
            // Update fields valid only during the pulse
            if (upd_seen && exp_upd) begin
                check_pte("up_content_o", exp_content, up_content_o);
                check_vpn("up_vpn_o", iova[38:12], up_vpn_o);
                check_pscid("up_pscid_o", vec_mem[b+1][ptw_pkg::PSCIDW-1:0], up_pscid_o);
                check_bit("up_1g_o", exp_size[1], up_1g_o);
                check_bit("up_2m_o", exp_size[0], up_2m_o);
            end
            tick();
            mem_r_valid_i = 1'b0;
            mem_r_err_i   = 1'b0;
            mem_r_data_i  = '0;
            @(negedge clk_i);
            if (upd_seen) begin
                // Already back in IDLE
                check_bit("update_o", 1'b0, update_o);
                check_bit("ptw_active_o", 1'b0, ptw_active_o);
                done = 1'b1;
            end else if (ptw_error_o) begin
                err_seen = 1'b1;
                if (!exp_upd) begin
                    check_cause("cause_code_o", exp_cause, cause_code_o);
                end
                check_bit("ptw_active_o", 1'b1, ptw_active_o);
                tick();
                @(negedge clk_i);
                check_bit("ptw_error_o", 1'b0, ptw_error_o);
                check_bit("ptw_active_o", 1'b0, ptw_active_o);
                done = 1'b1;
            end else if (mem_ar_valid_o && n < 2) begin
                // Next table indexed by the next VPN slice
                exp_addr = {cur_pte.ppn, (n == 0) ? iova[29:21] : iova[20:12], 3'b000};
                n++;
                tick();
            end else begin
                other_errors++;
                $display("Walk %0d: neither a result nor a new read after read %0d", v, n + 1);
                done = 1'b1;
            end
        end
        check_bit("update_o", exp_upd, upd_seen);
        check_bit("ptw_error_o", !exp_upd, err_seen);
    endtask

    initial begin
        int i;
        seed           = 32'hed8f;
        rst_ni         = 1'b0;
        init_ptw_i     = 1'b0;
        req_iova_i     = '0;
        pscid_i        = '0;
        iosatp_ppn_i   = '0;
        is_store_i     = 1'b0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i  = 1'b0;
        mem_r_data_i   = '0;
        mem_r_err_i    = 1'b0;
        num_checks     = 0;
        value_errors   = 0;
        other_errors   = 0;
        // Marker in the upper word makes unused lines stand out
        for (i = 0; i < NF*MAX_VECS; i++) begin
            vec_mem[i] = {32'hffff_ffff, i};
        end
        $readmemh("testbench/ptw_input.txt", vec_mem);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && vec_mem[num_vecs*NF][63:32] != 32'hffff_ffff) begin
            num_vecs++;
        end
        vecs_loaded = 1'b1;
        if (num_vecs == 0) begin
            other_errors++;
            $display("No stimulus lines read from testbench/ptw_input.txt");
        end
        // Idle outputs checked inside the ten reset cycles
        repeat (9) @(posedge clk_i);
        @(negedge clk_i);
        check_bit("mem_ar_valid_o", 1'b0, mem_ar_valid_o);
        check_bit("mem_r_ready_o", 1'b0, mem_r_ready_o);
        check_bit("update_o", 1'b0, update_o);
        check_bit("ptw_error_o", 1'b0, ptw_error_o);
        check_bit("ptw_active_o", 1'b0, ptw_active_o);
        tick();
        rst_ni = 1'b1;
        for (i = 0; i < num_vecs; i++) begin
            run_walk(i);
            repeat (2) tick();
        end
        $display("Summary: %0d checks, %0d value errors, %0d other errors",
                 num_checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog sized from the number of walks
    initial begin
        wait (vecs_loaded);
        repeat ((num_vecs + 1) * WALK_CYCLES) @(posedge clk_i);
        $display("Timeout: walks did not finish within %0d cycles",
                 (num_vecs + 1) * WALK_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/iommu_ptw.sv ====
`timescale 1ns/10ps
`default_nettype none

module iommu_ptw (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Walk request
    input  logic                         init_ptw_i,
    input  logic [ptw_pkg::VLEN-1:0]     req_iova_i,
    input  logic [ptw_pkg::PSCIDW-1:0]   pscid_i,
    input  logic [ptw_pkg::PPNW-1:0]     iosatp_ppn_i,
    input  logic                         is_store_i,
    // Read request channel
    output logic                         mem_ar_valid_o,
    output logic [ptw_pkg::PLEN-1:0]     mem_ar_addr_o,
    input  logic                         mem_ar_ready_i,
    // Read response channel
    input  logic                         mem_r_valid_i,
    input  logic [ptw_pkg::PTE_W-1:0]    mem_r_data_i,
    input  logic                         mem_r_err_i,
    output logic                         mem_r_ready_o,
    // IOTLB update
    output logic                         update_o,
    output logic [ptw_pkg::VPNW-1:0]     up_vpn_o,
    output logic [ptw_pkg::PSCIDW-1:0]   up_pscid_o,
    output logic                         up_1g_o,
    output logic                         up_2m_o,
    output ptw_pkg::pte_t                up_content_o,
    // Error report
    output logic                         ptw_error_o,
    output ptw_pkg::cause_e              cause_code_o,
    output logic                         ptw_active_o
);

    // Control strobes from the walk controller
    logic start;
    logic descend;
    logic accept;
    logic store;
    ptw_pkg::pt_level_e level;

    // Checker outcomes
    logic leaf;
    logic invalid;
    logic leaf_fault;
    logic nonleaf_fault;
    logic reserved_fault;

    // Response data seen as a PTE
    ptw_pkg::pte_t resp_pte;

    assign resp_pte = ptw_pkg::pte_t'(mem_r_data_i);

    // Sequencing of reads, levels and result pulses
    ptw_walk_ctrl u_walk_ctrl (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .init_ptw_i       (init_ptw_i),
        .is_store_i       (is_store_i),
        .mem_ar_ready_i   (mem_ar_ready_i),
        .mem_r_valid_i    (mem_r_valid_i),
        .mem_r_err_i      (mem_r_err_i),
        .leaf_i           (leaf),
        .invalid_i        (invalid),
        .leaf_fault_i     (leaf_fault),
        .nonleaf_fault_i  (nonleaf_fault),
        .reserved_fault_i (reserved_fault),
        .start_o          (start),
        .descend_o        (descend),
        .level_o          (level),
        .accept_o         (accept),
        .store_o          (store),
        .mem_ar_valid_o   (mem_ar_valid_o),
        .mem_r_ready_o    (mem_r_ready_o),
        .update_o         (update_o),
        .ptw_error_o      (ptw_error_o),
        .cause_code_o     (cause_code_o),
        .ptw_active_o     (ptw_active_o)
    );

    // PTE classification at the current level
    ptw_pte_check u_pte_check (
        .pte_i            (resp_pte),
        .level_i          (level),
        .is_store_i       (store),
        .leaf_o           (leaf),
        .invalid_o        (invalid),
        .leaf_fault_o     (leaf_fault),
        .nonleaf_fault_o  (nonleaf_fault),
        .reserved_fault_o (reserved_fault)
    );

    // Table pointer, drives the read address
    ptw_pptr_gen u_pptr_gen (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .descend_i    (descend),
        .level_i      (level),
        .req_iova_i   (req_iova_i),
        .iosatp_ppn_i (iosatp_ppn_i),
        .pte_ppn_i    (resp_pte.ppn),
        .pptr_o       (mem_ar_addr_o)
    );

    // IOTLB tags and update payload
    ptw_iotlb_update u_iotlb_update (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .start_i      (start),
        .accept_i     (accept),
        .level_i      (level),
        .req_iova_i   (req_iova_i),
        .pscid_i      (pscid_i),
        .pte_i        (resp_pte),
        .up_vpn_o     (up_vpn_o),
        .up_pscid_o   (up_pscid_o),
        .up_1g_o      (up_1g_o),
        .up_2m_o      (up_2m_o),
        .up_content_o (up_content_o)
    );

endmodule

`default_nettype wire

// ==== verilog/ptw_iotlb_update.sv ====
`timescale 1ns/10ps
`default_nettype none

module ptw_iotlb_update (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    input  logic                        start_i,
    input  logic                        accept_i,
    input  ptw_pkg::pt_level_e          level_i,
    input  logic [ptw_pkg::VLEN-1:0]    req_iova_i,
    input  logic [ptw_pkg::PSCIDW-1:0]  pscid_i,
    input  ptw_pkg::pte_t               pte_i,
    output logic [ptw_pkg::VPNW-1:0]    up_vpn_o,
    output logic [ptw_pkg::PSCIDW-1:0]  up_pscid_o,
    output logic                        up_1g_o,
    output logic                        up_2m_o,
    output ptw_pkg::pte_t               up_content_o
);

    // Tags captured at walk start
    logic [ptw_pkg::VPNW-1:0]   vpn_q;
    logic [ptw_pkg::PSCIDW-1:0] pscid_q;
    // Global seen on any earlier level
    logic                       global_q;
    // Leaf PTE as flat bits for the G override
    logic [ptw_pkg::PTE_W-1:0]  content;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vpn_q    <= '0;
            pscid_q  <= '0;
            global_q <= 1'b0;
        end else if (start_i) begin
            vpn_q    <= req_iova_i[ptw_pkg::VLEN-1:ptw_pkg::PGOFF];
            pscid_q  <= pscid_i;
            global_q <= 1'b0;
        end else if (accept_i) begin
            global_q <= global_q | pte_i.g;
        end
    end

    // Leaf G is ORed in directly, it arrives in the update cycle
    always_comb begin
        content                     = pte_i;
        content[ptw_pkg::G_BIT_POS] = pte_i.g | global_q;
    end

    assign up_content_o = ptw_pkg::pte_t'(content);
    assign up_vpn_o     = vpn_q;
    assign up_pscid_o   = pscid_q;

    // Leaf level gives the page size
    assign up_1g_o = (level_i == ptw_pkg::LVL1);
    assign up_2m_o = (level_i == ptw_pkg::LVL2);

endmodule

`default_nettype wire

// ==== verilog/ptw_pkg.sv ====
`default_nettype none

package ptw_pkg;

    // Sv39 physical address width
    localparam int unsigned PLEN = 56;
    // Physical page number width
    localparam int unsigned PPNW = 44;
    // IOVA width for Sv39
    localparam int unsigned VLEN = 39;
    // Full VPN width, three 9-bit slices
    localparam int unsigned VPNW = 27;
    // Width of one VPN slice
    localparam int unsigned VPN_SLICE = 9;
    // Page offset bits below the VPN
    localparam int unsigned PGOFF = 12;
    // Byte offset of an 8-byte PTE inside a table
    localparam int unsigned PTE_OFF = 3;
    // Raw PTE width on the memory port
    localparam int unsigned PTE_W = 64;
    // Process context ID width
    localparam int unsigned PSCIDW = 20;
    // Cause code width
    localparam int unsigned CAUSE_LEN = 12;
    // Global bit position inside the PTE
    localparam int unsigned G_BIT_POS = 5;

    // Sv39 page table entry, MSB first
    typedef struct packed {
        // Bits 63:54, must be zero
        logic [9:0]      reserved;
        logic [PPNW-1:0] ppn;
        // Reserved for software
        logic [1:0]      rsw;
        logic            d;
        logic            a;
        logic            g;
        logic            u;
        logic            x;
        logic            w;
        logic            r;
        logic            v;
    } pte_t;

    // Walk controller states
    typedef enum logic [1:0] {
        IDLE,
        MEM_ACCESS,
        PROC_PTE,
        ERROR
    } walk_state_e;

    // Walk levels: 1 GiB, 2 MiB, 4 KiB
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } pt_level_e;

    // Error causes reported by the walker
    typedef enum logic [CAUSE_LEN-1:0] {
        LOAD_PAGE_FAULT    = 12'd13,
        STORE_PAGE_FAULT   = 12'd15,
        PT_DATA_CORRUPTION = 12'd274
    } cause_e;

endpackage

`default_nettype wire

// ==== verilog/ptw_pptr_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module ptw_pptr_gen (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      start_i,
    input  logic                      descend_i,
    input  ptw_pkg::pt_level_e        level_i,
    input  logic [ptw_pkg::VLEN-1:0]  req_iova_i,
    input  logic [ptw_pkg::PPNW-1:0]  iosatp_ppn_i,
    input  logic [ptw_pkg::PPNW-1:0]  pte_ppn_i,
    output logic [ptw_pkg::PLEN-1:0]  pptr_o
);

    // VPN of the walk in progress
    logic [ptw_pkg::VPNW-1:0]      vpn_q;
    // Current table entry address
    logic [ptw_pkg::PLEN-1:0]      pptr_q, pptr_d;
    // VPN[2] straight from the request
    logic [ptw_pkg::VPN_SLICE-1:0] root_idx;
    // Index into the next table
    logic [ptw_pkg::VPN_SLICE-1:0] next_idx;

    assign root_idx = req_iova_i[ptw_pkg::VLEN-1 -: ptw_pkg::VPN_SLICE];

    // Leaving level 1 uses VPN[1], leaving level 2 uses VPN[0]
    always_comb begin
        if (level_i == ptw_pkg::LVL1) begin
            next_idx = vpn_q[2*ptw_pkg::VPN_SLICE-1 -: ptw_pkg::VPN_SLICE];
        end else begin
            next_idx = vpn_q[ptw_pkg::VPN_SLICE-1:0];
        end
    end

    always_comb begin
        pptr_d = pptr_q;
        if (start_i) begin
            // Root table from iosatp
            pptr_d = {iosatp_ppn_i, root_idx, {ptw_pkg::PTE_OFF{1'b0}}};
        end else if (descend_i) begin
            // Next table from the pointer PTE
            pptr_d = {pte_ppn_i, next_idx, {ptw_pkg::PTE_OFF{1'b0}}};
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            pptr_q <= '0;
            vpn_q  <= '0;
        end else begin
            pptr_q <= pptr_d;
            if (start_i) begin
                vpn_q <= req_iova_i[ptw_pkg::VLEN-1:ptw_pkg::PGOFF];
            end
        end
    end

    // Stable while the request waits for ready
    assign pptr_o = pptr_q;

endmodule

`default_nettype wire

// ==== verilog/ptw_pte_check.sv ====
`timescale 1ns/10ps
`default_nettype none

module ptw_pte_check (
    input  ptw_pkg::pte_t      pte_i,
    input  ptw_pkg::pt_level_e level_i,
    input  logic               is_store_i,
    output logic               leaf_o,
    output logic               invalid_o,
    output logic               leaf_fault_o,
    output logic               nonleaf_fault_o,
    output logic               reserved_fault_o
);

    // PPN bits that must be clear for a superpage leaf
    logic [ptw_pkg::PPNW-1:0] align_mask;
    logic                     misaligned;
    // Leaf permission and A/D failures
    logic                     perm_fault;

    // Mask width follows the size of the superpage
    always_comb begin
        align_mask = '0;
        case (level_i)
            ptw_pkg::LVL1: align_mask[17:0] = '1;
            ptw_pkg::LVL2: align_mask[8:0]  = '1;
            default:       align_mask       = '0;
        endcase
    end

    assign misaligned = |(pte_i.ppn & align_mask);

    // Not valid, or write without read
    assign invalid_o = !pte_i.v || (pte_i.w && !pte_i.r);

    // Readable or executable marks a leaf
    assign leaf_o = pte_i.r || pte_i.x;

    // A clear, R clear, or store to a clean page
    assign perm_fault = !pte_i.a || !pte_i.r || (is_store_i && !pte_i.d);

    assign leaf_fault_o = leaf_o && (misaligned || perm_fault);

    // A/D/U are reserved in pointers; no table below level 3
    assign nonleaf_fault_o = !leaf_o &&
                             (pte_i.a || pte_i.d || pte_i.u || (level_i == ptw_pkg::LVL3));

    // Upper PTE bits must be zero
    assign reserved_fault_o = |pte_i.reserved;

endmodule

`default_nettype wire

// ==== verilog/ptw_walk_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ptw_walk_ctrl (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               init_ptw_i,
    input  logic               is_store_i,
    input  logic               mem_ar_ready_i,
    input  logic               mem_r_valid_i,
    input  logic               mem_r_err_i,
    // Checker outcomes for the response on the bus
    input  logic               leaf_i,
    input  logic               invalid_i,
    input  logic               leaf_fault_i,
    input  logic               nonleaf_fault_i,
    input  logic               reserved_fault_i,
    // Strobes to the datapath units
    output logic               start_o,
    output logic               descend_o,
    output ptw_pkg::pt_level_e level_o,
    output logic               accept_o,
    output logic               store_o,
    // Memory handshakes
    output logic               mem_ar_valid_o,
    output logic               mem_r_ready_o,
    // Walk results
    output logic               update_o,
    output logic               ptw_error_o,
    output ptw_pkg::cause_e    cause_code_o,
    output logic               ptw_active_o
);

    ptw_pkg::walk_state_e state_q, state_d;
    ptw_pkg::pt_level_e   level_q, level_d;

    // Page fault seen during the walk
    logic pf_q, pf_d;
    // Response came back with the error bit
    logic mem_err_q, mem_err_d;
    // Access type sampled at start
    logic store_q, store_d;

    assign level_o      = level_q;
    assign store_o      = store_q;
    assign ptw_active_o = (state_q != ptw_pkg::IDLE);

    always_comb begin
        state_d        = state_q;
        level_d        = level_q;
        pf_d           = pf_q;
        mem_err_d      = mem_err_q;
        store_d        = store_q;
        start_o        = 1'b0;
        descend_o      = 1'b0;
        accept_o       = 1'b0;
        mem_ar_valid_o = 1'b0;
        mem_r_ready_o  = 1'b0;
        update_o       = 1'b0;
        ptw_error_o    = 1'b0;
        cause_code_o   = ptw_pkg::LOAD_PAGE_FAULT;

        case (state_q)
            ptw_pkg::IDLE: begin
                // New walk always begins at the root table
                if (init_ptw_i) begin
                    start_o   = 1'b1;
                    state_d   = ptw_pkg::MEM_ACCESS;
                    level_d   = ptw_pkg::LVL1;
                    pf_d      = 1'b0;
                    mem_err_d = 1'b0;
                    store_d   = is_store_i;
                end
            end

            ptw_pkg::MEM_ACCESS: begin
                // Hold the request until the port takes it
                mem_ar_valid_o = 1'b1;
                if (mem_ar_ready_i) begin
                    state_d = ptw_pkg::PROC_PTE;
                end
            end

            ptw_pkg::PROC_PTE: begin
                if (mem_r_valid_i) begin
                    mem_r_ready_o = 1'b1;
                    accept_o      = 1'b1;
                    // Bus error wins over any PTE check
                    if (mem_r_err_i) begin
                        mem_err_d = 1'b1;
                        state_d   = ptw_pkg::ERROR;
                    end else if (invalid_i || reserved_fault_i) begin
                        pf_d    = 1'b1;
                        state_d = ptw_pkg::ERROR;
                    end else if (leaf_i) begin
                        if (leaf_fault_i) begin
                            pf_d    = 1'b1;
                            state_d = ptw_pkg::ERROR;
                        end else begin
                            // Good leaf, translation complete
                            update_o = 1'b1;
                            state_d  = ptw_pkg::IDLE;
                        end
                    end else if (nonleaf_fault_i) begin
                        pf_d    = 1'b1;
                        state_d = ptw_pkg::ERROR;
                    end else begin
                        // Pointer to the next table
                        descend_o = 1'b1;
                        state_d   = ptw_pkg::MEM_ACCESS;
                        level_d   = (level_q == ptw_pkg::LVL1) ? ptw_pkg::LVL2 : ptw_pkg::LVL3;
                    end
                end
            end

            ptw_pkg::ERROR: begin
                ptw_error_o = 1'b1;
                state_d     = ptw_pkg::IDLE;
                if (mem_err_q) begin
                    cause_code_o = ptw_pkg::PT_DATA_CORRUPTION;
                end else if (pf_q) begin
                    // Fault type follows the original access
                    cause_code_o = store_q ? ptw_pkg::STORE_PAGE_FAULT
                                           : ptw_pkg::LOAD_PAGE_FAULT;
                end
            end

            default: begin
                state_d = ptw_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= ptw_pkg::IDLE;
            level_q   <= ptw_pkg::LVL1;
            pf_q      <= 1'b0;
            mem_err_q <= 1'b0;
            store_q   <= 1'b0;
        end else begin
            state_q   <= state_d;
            level_q   <= level_d;
            pf_q      <= pf_d;
            mem_err_q <= mem_err_d;
            store_q   <= store_d;
        end
    end

endmodule

`default_nettype wire
